/* rapcore_macros.svh */
`ifndef RAPCORE_MACROS_SVH
`define RAPCORE_MACROS_SVH

// Datapath widths
`define ENC_BITS 32
`define PWM_BITS 8
`define PHASE_BITS 5   // 32 microsteps per electrical cycle

// Equal samples needed before a filtered pin moves
`define FILTER_LEN 3

// SPI frame is one command byte then 32 data bits
`define FRAME_BITS 40

// Command codes
`define CMD_WRITE_CFG  8'h10
`define CMD_STEP       8'h20
`define CMD_READ_ENC   8'h30
`define CMD_READ_FAULT 8'h31

`endif

/* motor_cfg_pkg.sv */
package motor_cfg_pkg;

  // Motor configuration as held by the SPI register file
  typedef struct packed {
    logic       enable;      // Drive outputs allowed
    logic [1:0] microsteps;  // Resolution code, 0 is coarsest
    logic [7:0] current;     // Amplitude scale applied to the sine table
  } motor_cfg_t;

  // Step request towards the microstepper
  typedef struct packed {
    logic step;  // One-cycle pulse
    logic dir;   // 1 moves forward
  } step_cmd_t;

endpackage

/* motor_io_pkg.sv */
package motor_io_pkg;

  // SPI slave pins
  typedef struct packed {
    logic sck;
    logic cs;    // Active low
    logic copi;
  } spi_pins_t;

  // Quadrature encoder channels
  typedef struct packed {
    logic a;
    logic b;
  } enc_pins_t;

  // Half-bridge enables of one coil
  typedef struct packed {
    logic pos;  // Current flows forward through the coil
    logic neg;  // Current flows backward
  } coil_drive_t;

endpackage

/* input_filter.sv */
`timescale 1ns/1ps
`include "rapcore_macros.svh"

module input_filter #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     resetn,
  input  payload_t reset_value,
  input  payload_t raw,
  output payload_t filtered
);

  localparam int CNT_W = $clog2(`FILTER_LEN + 1);

  payload_t         sync_1;
  payload_t         sync_2;
  logic [CNT_W-1:0] diff_cnt;  // Cycles sync_2 has disagreed with the output

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sync_1   <= reset_value;
      sync_2   <= reset_value;
      filtered <= reset_value;
      diff_cnt <= '0;
    end else begin
      sync_1 <= raw;
      sync_2 <= sync_1;
      if (sync_2 == filtered) begin
        diff_cnt <= '0;
      end else if (diff_cnt == CNT_W'(`FILTER_LEN - 1)) begin
        filtered <= sync_2;  // Held long enough, accept it
        diff_cnt <= '0;
      end else begin
        diff_cnt <= diff_cnt + 1'b1;
      end
    end
  end

endmodule

/* spi_register_file.sv */
`timescale 1ns/1ps
`include "rapcore_macros.svh"

module spi_register_file (
  input  logic                        CLK,
  input  logic                        resetn,
  input  motor_io_pkg::spi_pins_t     spi,
  output logic                        cipo,
  input  logic signed [`ENC_BITS-1:0] enc_count,
  input  logic                        enc_faultn,
  output motor_cfg_pkg::motor_cfg_t   cfg,
  output motor_cfg_pkg::step_cmd_t    step_cmd
);

  localparam int CNT_W     = $clog2(`FRAME_BITS + 1);
  localparam int DATA_BITS = `FRAME_BITS - 8;

  logic                   sck_q;
  logic                   cs_q;
  logic                   sck_rise;
  logic                   sck_fall;
  logic                   cs_fall;
  logic                   cs_rise;
  logic [CNT_W-1:0]       bit_cnt;
  logic                   in_data_phase;
  logic [`FRAME_BITS-1:0] rx_shift;
  logic [DATA_BITS-1:0]   tx_shift;
  logic [7:0]             cmd_byte;
  logic [7:0]             frame_cmd;
  logic [DATA_BITS-1:0]   frame_data;
  logic                   frame_ok;

  // Edges of the filtered pins
  assign sck_rise = spi.sck & ~sck_q;
  assign sck_fall = ~spi.sck & sck_q;
  assign cs_fall  = ~spi.cs & cs_q;
  assign cs_rise  = spi.cs & ~cs_q;

  assign in_data_phase = (bit_cnt >= CNT_W'(8)) && (bit_cnt < CNT_W'(`FRAME_BITS));

  assign cmd_byte   = {rx_shift[6:0], spi.copi};  // Valid on the eighth rising edge
  assign frame_cmd  = rx_shift[`FRAME_BITS-1 -: 8];
  assign frame_data = rx_shift[DATA_BITS-1:0];
  assign frame_ok   = (bit_cnt == CNT_W'(`FRAME_BITS));

  // Frame tracking and CIPO
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q   <= 1'b0;
      cs_q    <= 1'b1;
      bit_cnt <= '0;
      cipo    <= 1'b0;
    end else begin
      sck_q <= spi.sck;
      cs_q  <= spi.cs;
      if (cs_fall) begin
        bit_cnt <= '0;
        cipo    <= 1'b0;
      end else if (!spi.cs) begin
        // Saturate so an overlong frame never wraps back to a valid length
        if (sck_rise && bit_cnt != '1) begin
          bit_cnt <= bit_cnt + 1'b1;
        end
        if (sck_fall) begin
          cipo <= in_data_phase ? tx_shift[DATA_BITS-1] : 1'b0;
        end
      end else begin
        cipo <= 1'b0;  // Bus idle
      end
    end
  end

  // Receive and transmit shifters
  always_ff @(posedge CLK) begin
    if (!spi.cs && sck_rise) begin
      rx_shift <= {rx_shift[`FRAME_BITS-2:0], spi.copi};
      if (bit_cnt == CNT_W'(7)) begin
        case (cmd_byte)
          `CMD_READ_ENC:   tx_shift <= DATA_BITS'(enc_count);
          `CMD_READ_FAULT: tx_shift <= {{(DATA_BITS-1){1'b0}}, ~enc_faultn};
          default:         tx_shift <= '0;
        endcase
      end
    end else if (!spi.cs && sck_fall && in_data_phase) begin
      tx_shift <= {tx_shift[DATA_BITS-2:0], 1'b0};  // MSB first
    end
  end

  // Command execution once cs releases
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      cfg      <= '0;
      step_cmd <= '0;
    end else begin
      step_cmd.step <= 1'b0;
      if (cs_rise && frame_ok) begin
        case (frame_cmd)
          `CMD_WRITE_CFG: begin
            cfg.enable     <= frame_data[0];
            cfg.microsteps <= frame_data[2:1];
            cfg.current    <= frame_data[15:8];
          end
          `CMD_STEP: begin
            step_cmd.step <= 1'b1;
            step_cmd.dir  <= frame_data[0];
          end
          default: begin
            // Reads need nothing at the end of the frame
          end
        endcase
      end
    end
  end

endmodule

/* microstepper.sv */
`timescale 1ns/1ps
`include "rapcore_macros.svh"

module microstepper (
  input  logic                      CLK,
  input  logic                      resetn,
  input  motor_cfg_pkg::motor_cfg_t cfg,
  input  motor_cfg_pkg::step_cmd_t  step_cmd,
  output motor_io_pkg::coil_drive_t coil_a,
  output motor_io_pkg::coil_drive_t coil_b
);

  // Quarter-wave cosine, 0 to 90 degrees in eight steps
  localparam logic [7:0] COS_TABLE [0:8] = '{
    8'd255, 8'd250, 8'd236, 8'd212, 8'd180, 8'd142, 8'd98, 8'd50, 8'd0
  };

  localparam logic [`PHASE_BITS-1:0] B_LAG = `PHASE_BITS'(24);  // 270 degrees

  logic [`PHASE_BITS-1:0] phase_idx;
  logic [`PHASE_BITS-1:0] step_size;
  logic [`PHASE_BITS-1:0] idx_b;
  logic [`PWM_BITS-1:0]   pwm_cnt;
  logic [7:0]             mag_a;
  logic [7:0]             mag_b;
  logic [15:0]            prod_a;
  logic [15:0]            prod_b;
  logic [`PWM_BITS-1:0]   duty_a;
  logic [`PWM_BITS-1:0]   duty_b;
  logic                   active_a;
  logic                   active_b;

  function automatic logic [7:0] coil_mag(input logic [`PHASE_BITS-1:0] idx);
    logic [3:0] offset;
    offset = {1'b0, idx[2:0]};
    // Odd quadrants walk the table backwards
    if (idx[3]) begin
      coil_mag = COS_TABLE[4'd8 - offset];
    end else begin
      coil_mag = COS_TABLE[offset];
    end
  endfunction

  function automatic logic coil_positive(input logic [`PHASE_BITS-1:0] idx);
    logic [1:0] quadrant;
    quadrant = idx[`PHASE_BITS-1 -: 2];
    coil_positive = (quadrant == 2'd0) || (quadrant == 2'd3);
  endfunction

  assign step_size = `PHASE_BITS'(8) >> cfg.microsteps;
  assign idx_b     = phase_idx + B_LAG;

  assign mag_a  = coil_mag(phase_idx);
  assign mag_b  = coil_mag(idx_b);
  assign prod_a = mag_a * cfg.current;
  assign prod_b = mag_b * cfg.current;
  assign duty_a = prod_a[15 -: `PWM_BITS];
  assign duty_b = prod_b[15 -: `PWM_BITS];

  assign active_a = pwm_cnt < duty_a;
  assign active_b = pwm_cnt < duty_b;

  // Phase index and free-running PWM counter
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      phase_idx <= '0;
      pwm_cnt   <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (step_cmd.step) begin
        phase_idx <= step_cmd.dir ? phase_idx + step_size : phase_idx - step_size;
      end
    end
  end

  // Registered bridge drive
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      coil_a <= '0;
      coil_b <= '0;
    end else begin
      coil_a.pos <= cfg.enable && active_a && coil_positive(phase_idx);
      coil_a.neg <= cfg.enable && active_a && !coil_positive(phase_idx);
      coil_b.pos <= cfg.enable && active_b && coil_positive(idx_b);
      coil_b.neg <= cfg.enable && active_b && !coil_positive(idx_b);
    end
  end

endmodule

/* quad_enc.sv */
`timescale 1ns/1ps
`include "rapcore_macros.svh"

module quad_enc (
  input  logic                        CLK,
  input  logic                        resetn,
  input  motor_io_pkg::enc_pins_t     enc,
  output logic signed [`ENC_BITS-1:0] count,
  output logic                        faultn
);

  motor_io_pkg::enc_pins_t enc_q;  // Previous filtered state
  logic                    a_moved;
  logic                    b_moved;
  logic                    count_up;

  assign a_moved = enc.a ^ enc_q.a;
  assign b_moved = enc.b ^ enc_q.b;

  // New A differs from old B exactly when A leads B
  assign count_up = enc.a ^ enc_q.b;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enc_q  <= '0;
      count  <= '0;
      faultn <= 1'b1;
    end else begin
      enc_q <= enc;
      if (a_moved && b_moved) begin
        faultn <= 1'b0;  // Skipped a state, direction unknown
      end else if (a_moved || b_moved) begin
        if (count_up) begin
          count <= count + 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

/* rapcore_top.sv */
`timescale 1ns/1ps
`include "rapcore_macros.svh"

module rapcore_top (
  input  logic CLK,
  input  logic resetn,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  input  logic ENC_A,
  input  logic ENC_B,
  output logic CIPO,
  output logic PHASE_A1,
  output logic PHASE_A2,
  output logic PHASE_B1,
  output logic PHASE_B2,
  output logic ENC_FAULTN
);

  // Idle pin states
  localparam motor_io_pkg::spi_pins_t SPI_IDLE = '{sck: 1'b0, cs: 1'b1, copi: 1'b0};
  localparam motor_io_pkg::enc_pins_t ENC_IDLE = '{a: 1'b0, b: 1'b0};

  motor_io_pkg::spi_pins_t      spi_raw;
  motor_io_pkg::spi_pins_t      spi_filt;
  motor_io_pkg::enc_pins_t      enc_raw;
  motor_io_pkg::enc_pins_t      enc_filt;
  motor_cfg_pkg::motor_cfg_t    cfg;
  motor_cfg_pkg::step_cmd_t     step_cmd;
  motor_io_pkg::coil_drive_t    coil_a;
  motor_io_pkg::coil_drive_t    coil_b;
  logic signed [`ENC_BITS-1:0] enc_count;

  assign spi_raw.sck  = SCK;
  assign spi_raw.cs   = CS;
  assign spi_raw.copi = COPI;
  assign enc_raw.a    = ENC_A;
  assign enc_raw.b    = ENC_B;

  input_filter #(.payload_t(motor_io_pkg::spi_pins_t)) spi_filter (
    .CLK(CLK), .resetn(resetn), .reset_value(SPI_IDLE), .raw(spi_raw), .filtered(spi_filt)
  );

  input_filter #(.payload_t(motor_io_pkg::enc_pins_t)) enc_filter (
    .CLK(CLK), .resetn(resetn), .reset_value(ENC_IDLE), .raw(enc_raw), .filtered(enc_filt)
  );

  spi_register_file regs (
    .CLK(CLK), .resetn(resetn), .spi(spi_filt), .cipo(CIPO), .enc_count(enc_count),
    .enc_faultn(ENC_FAULTN), .cfg(cfg), .step_cmd(step_cmd)
  );

  microstepper stepper (
    .CLK(CLK), .resetn(resetn), .cfg(cfg), .step_cmd(step_cmd),
    .coil_a(coil_a), .coil_b(coil_b)
  );

  quad_enc encoder (
    .CLK(CLK), .resetn(resetn), .enc(enc_filt), .count(enc_count), .faultn(ENC_FAULTN)
  );

  assign PHASE_A1 = coil_a.pos;
  assign PHASE_A2 = coil_a.neg;
  assign PHASE_B1 = coil_b.pos;
  assign PHASE_B2 = coil_b.neg;

endmodule

/* rapcore_assert.sv */
`timescale 1ns/1ps

module rapcore_assert (
  input logic CLK,
  input logic resetn,
  input logic PHASE_A1,
  input logic PHASE_A2,
  input logic PHASE_B1,
  input logic PHASE_B2,
  input logic ENC_FAULTN
);

  // Both half-bridges of a coil on at once would short the supply
  coil_a_exclusive: assert property (@(posedge CLK) !(PHASE_A1 && PHASE_A2))
    else $error("Coil A pos and neg enabled together");

  coil_b_exclusive: assert property (@(posedge CLK) !(PHASE_B1 && PHASE_B2))
    else $error("Coil B pos and neg enabled together");

  phases_off_after_reset: assert property (
    @(posedge CLK) $rose(resetn) |-> !(PHASE_A1 || PHASE_A2 || PHASE_B1 || PHASE_B2))
    else $error("Phase output active right after reset release");

  // Only reset may clear the encoder fault
  fault_sticky: assert property (
    @(posedge CLK) (resetn && $past(resetn) && !$past(ENC_FAULTN)) |-> !ENC_FAULTN)
    else $error("ENC_FAULTN rose without a reset");

endmodule

bind rapcore_top rapcore_assert rapcore_assert_inst (
  .CLK(CLK), .resetn(resetn), .PHASE_A1(PHASE_A1), .PHASE_A2(PHASE_A2),
  .PHASE_B1(PHASE_B1), .PHASE_B2(PHASE_B2), .ENC_FAULTN(ENC_FAULTN)
);

/* tb_rapcore.sv */
`timescale 1ns/1ps
`include "rapcore_macros.svh"

module tb_rapcore;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;
  localparam int HALF_SCK     = 8;   // CLK cycles per SCK half period
  localparam int ENC_HOLD     = 10;
  localparam int WINDOW       = 256;
  localparam int N_STEPS      = 20;
  localparam int N_MOVES      = 40;
  localparam int FRAME_CYCLES = HALF_SCK * (2 * `FRAME_BITS + 4);
  // Reset plus tests 1 to 6
  localparam int BUDGET = 3 + (16 + FRAME_CYCLES) + (FRAME_CYCLES + WINDOW)
    + (N_STEPS * FRAME_CYCLES + WINDOW) + (2 * FRAME_CYCLES + 2 * WINDOW)
    + (N_MOVES * ENC_HOLD + 2 * FRAME_CYCLES) + (20 + 2 * FRAME_CYCLES);

  localparam int SINE_MAG [0:8] = '{255, 250, 236, 212, 180, 142, 98, 50, 0};
  localparam logic [1:0] GRAY_AB [0:3] = '{2'b00, 2'b10, 2'b11, 2'b01};  // {a, b} with a leading

  logic CLK;
  logic resetn;
  logic SCK;
  logic CS;
  logic COPI;
  logic ENC_A;
  logic ENC_B;
  logic CIPO;
  logic PHASE_A1;
  logic PHASE_A2;
  logic PHASE_B1;
  logic PHASE_B2;
  logic ENC_FAULTN;

  // Reference model state
  logic       m_enable;
  logic [1:0] m_micro;
  logic [7:0] m_current;
  int         m_idx;
  int         m_count;
  int         enc_pos;
  int         duty_tab [0:31];
  logic       pos_tab [0:31];

  string       cur_test;
  int          checks;
  int          errors;
  int          err_base;
  int          tests_failed;
  logic [31:0] rd;
  logic        dir;

  rapcore_top rapcore_top_inst (
    .CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI), .ENC_A(ENC_A),
    .ENC_B(ENC_B), .CIPO(CIPO), .PHASE_A1(PHASE_A1), .PHASE_A2(PHASE_A2),
    .PHASE_B1(PHASE_B1), .PHASE_B2(PHASE_B2), .ENC_FAULTN(ENC_FAULTN)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  initial begin
    repeat (2 * BUDGET) @(posedge CLK);
    $display("Watchdog expired in test %s, simulation stopped", cur_test);
    $display("Regression failed");
    $finish;
  end

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #DRIVE_DELAY;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED: test %s, %s, expected 0x%08h, actual 0x%08h",
               cur_test, what, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_base = errors;
  endtask

  task automatic finish_test();
    if (errors == err_base) begin
      $display("Test %s ok", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s FAILED with %0d errors", cur_test, errors - err_base);
    end
  endtask

  // One mode 0 frame sent MSB first
  task automatic spi_frame(input logic [7:0] cmd, input logic [31:0] data,
                           output logic [31:0] rdata);
    logic [`FRAME_BITS-1:0] frame;
    int i;
    frame = {cmd, data};
    rdata = '0;
    CS = 1'b0;
    wait_cycles(HALF_SCK);
    for (i = `FRAME_BITS - 1; i >= 0; i--) begin
      COPI = frame[i];
      wait_cycles(HALF_SCK);
      // Host samples CIPO just before the rising SCK
      if (i < 32) begin
        rdata = {rdata[30:0], CIPO};
      end
      SCK = 1'b1;
      wait_cycles(HALF_SCK);
      SCK = 1'b0;
    end
    wait_cycles(HALF_SCK);
    CS   = 1'b1;
    COPI = 1'b0;
    wait_cycles(2 * HALF_SCK);  // Let the command land
  endtask

  task automatic rebuild_duty_table();
    int i;
    int quadrant;
    int offset;
    int mag;
    for (i = 0; i < 32; i++) begin
      quadrant = i / 8;
      offset   = i % 8;
      mag = (quadrant % 2 == 0) ? SINE_MAG[offset] : SINE_MAG[8 - offset];
      duty_tab[i] = (mag * m_current) / 256;
      pos_tab[i]  = (quadrant == 0) || (quadrant == 3);
    end
  endtask

  task automatic write_cfg(input logic enable, input logic [1:0] micro,
                           input logic [7:0] current);
    logic [31:0] unused;
    spi_frame(`CMD_WRITE_CFG, {16'h0, current, 5'h0, micro, enable}, unused);
    m_enable  = enable;
    m_micro   = micro;
    m_current = current;
    rebuild_duty_table();
  endtask

  // Active cycles per phase pin over one PWM period
  task automatic check_window();
    int a1 = 0;
    int a2 = 0;
    int b1 = 0;
    int b2 = 0;
    int idx_b;
    int duty_a;
    int duty_b;
    idx_b  = (m_idx + 24) % 32;
    duty_a = m_enable ? duty_tab[m_idx] : 0;
    duty_b = m_enable ? duty_tab[idx_b] : 0;
    repeat (WINDOW) begin
      wait_cycles(1);
      a1 += PHASE_A1;
      a2 += PHASE_A2;
      b1 += PHASE_B1;
      b2 += PHASE_B2;
    end
    check_value("PHASE_A1 count", pos_tab[m_idx] ? duty_a : 0, a1);
    check_value("PHASE_A2 count", pos_tab[m_idx] ? 0 : duty_a, a2);
    check_value("PHASE_B1 count", pos_tab[idx_b] ? duty_b : 0, b1);
    check_value("PHASE_B2 count", pos_tab[idx_b] ? 0 : duty_b, b2);
  endtask

  task automatic enc_move(input logic fwd);
    enc_pos = fwd ? (enc_pos + 1) % 4 : (enc_pos + 3) % 4;
    {ENC_A, ENC_B} = GRAY_AB[enc_pos];
    m_count += fwd ? 1 : -1;
    wait_cycles(ENC_HOLD);
  endtask

  initial begin
    CLK = 1'b0;
    resetn = 1'b0;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    ENC_A = 1'b0;
    ENC_B = 1'b0;
    checks = 0;
    errors = 0;
    tests_failed = 0;
    m_idx = 0;
    m_count = 0;
    enc_pos = 0;
    cur_test = "reset";
    void'($urandom(32'h36f4_e204));
    wait_cycles(3);
    resetn = 1'b1;

    start_test("reset");
    wait_cycles(8);
    check_value("phase outputs", 4'b0000, {PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2});
    check_value("ENC_FAULTN", 1, ENC_FAULTN);
    spi_frame(`CMD_READ_ENC, '0, rd);
    check_value("encoder count", 0, rd);
    finish_test();

    start_test("duty_idx0");
    write_cfg(1'b1, 2'($urandom_range(0, 3)), 8'($urandom_range(0, 255)));
    check_window();
    finish_test();

    start_test("random_steps");
    repeat (N_STEPS) begin
      dir = 1'($urandom_range(0, 1));
      spi_frame(`CMD_STEP, {31'h0, dir}, rd);
      m_idx = dir ? (m_idx + (8 >> m_micro)) % 32 : (m_idx + 32 - (8 >> m_micro)) % 32;
    end
    check_window();
    finish_test();

    start_test("disable");
    write_cfg(1'b0, m_micro, m_current);
    check_window();  // Expects silence
    write_cfg(1'b1, m_micro, m_current);
    check_window();
    finish_test();

    start_test("enc_moves");
    repeat (N_MOVES) enc_move(1'($urandom_range(0, 1)));
    spi_frame(`CMD_READ_ENC, '0, rd);
    check_value("encoder count", m_count, rd);
    spi_frame(`CMD_READ_FAULT, '0, rd);
    check_value("fault flag", 0, rd);
    finish_test();

    start_test("enc_fault");
    ENC_A = ~ENC_A;
    ENC_B = ~ENC_B;
    for (int n = 0; n < 20 && ENC_FAULTN; n++) wait_cycles(1);
    checks++;
    assert (!ENC_FAULTN) else begin
      errors++;
      $display("Test %s: ENC_FAULTN stayed high after A and B flipped together", cur_test);
    end
    spi_frame(`CMD_READ_FAULT, '0, rd);
    check_value("fault flag", 1, rd);
    spi_frame(`CMD_READ_ENC, '0, rd);
    check_value("encoder count", m_count, rd);
    finish_test();

    $display("6 tests, %0d failed, %0d checks, %0d errors", tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
motor_cfg_pkg.sv
motor_io_pkg.sv
input_filter.sv
spi_register_file.sv
microstepper.sv
quad_enc.sv
rapcore_top.sv
rapcore_assert.sv
tb_rapcore.sv

/* Bender.yml */
package:
  name: rapcore

sources:
  - include_dirs:
      - .
    files:
      - motor_cfg_pkg.sv
      - motor_io_pkg.sv
      - input_filter.sv
      - spi_register_file.sv
      - microstepper.sv
      - quad_enc.sv
      - rapcore_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rapcore_assert.sv
      - tb_rapcore.sv
